/* common/rename_pkg.sv */
package rename_pkg;

  // architectural and physical register file sizes
  localparam int ARCH_REGS = 32;
  localparam int PHYS_REGS = 64;
  localparam int AREG_W = 5;
  localparam int PREG_W = 6;

  // group width
  localparam int SLOTS = 2;

  // retire queue sizing
  localparam int RQ_DEPTH = 16;
  localparam int RQ_PTR_W = 4;
  // occupancy 0..RQ_DEPTH
  localparam int RQ_CNT_W = 5;

  // free count 0..PHYS_REGS
  localparam int FREE_CNT_W = 7;

  // opcodes that write rd
  localparam logic [6:0] OPC_OP = 7'b0110011;
  localparam logic [6:0] OPC_IMM = 7'b0010011;

  // register-register form
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } insn_r_t;

  // register-immediate form, imm12 overlays funct7 and rs2
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } insn_i_t;

  typedef union packed {
    insn_r_t r;
    insn_i_t i;
  } insn_word_t;

endpackage

/* rtl/decode/insn_decode.sv */
module insn_decode (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  output logic in_ready,
  input  logic [rename_pkg::SLOTS-1:0] in_slot_en,
  input  rename_pkg::insn_word_t [rename_pkg::SLOTS-1:0] in_insn,
  output logic dec_valid,
  input  logic dec_ready,
  output logic [rename_pkg::SLOTS-1:0] dec_slot_en,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::AREG_W-1:0] dec_rs1,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::AREG_W-1:0] dec_rs2,
  output logic [rename_pkg::SLOTS-1:0] dec_rs2_en,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::AREG_W-1:0] dec_rd,
  output logic [rename_pkg::SLOTS-1:0] dec_wr_en
);
  import rename_pkg::*;

  logic [SLOTS-1:0] is_op;
  logic [SLOTS-1:0] is_imm;
  logic [SLOTS-1:0][AREG_W-1:0] nxt_rs1;
  logic [SLOTS-1:0][AREG_W-1:0] nxt_rs2;
  logic [SLOTS-1:0][AREG_W-1:0] nxt_rd;
  logic [SLOTS-1:0] nxt_rs2_en;
  logic [SLOTS-1:0] nxt_wr_en;

  // opcode through each view, then the register fields
  always_comb begin
    for (int s = 0; s < SLOTS; s++) begin
      is_op[s] = in_insn[s].r.opcode == OPC_OP;
      is_imm[s] = in_insn[s].i.opcode == OPC_IMM;
      // rs1 and rd share their bits in both forms
      nxt_rs1[s] = in_insn[s].r.rs1;
      nxt_rd[s] = in_insn[s].r.rd;
      // only reg-reg reads a second source, elsewhere rs2 bits are immediate
      nxt_rs2[s] = is_op[s] ? in_insn[s].r.rs2 : '0;
      nxt_rs2_en[s] = in_slot_en[s] && is_op[s];
      // x0 is never renamed
      nxt_wr_en[s] = in_slot_en[s] && (is_op[s] || is_imm[s]) && (nxt_rd[s] != '0);
    end
  end

  // single stage skid-free output register
  assign in_ready = !dec_valid || dec_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else if (in_ready) begin
      dec_valid <= in_valid;
    end
  end

  // payload loads on the input handshake only
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      dec_slot_en <= in_slot_en;
      dec_rs1 <= nxt_rs1;
      dec_rs2 <= nxt_rs2;
      dec_rs2_en <= nxt_rs2_en;
      dec_rd <= nxt_rd;
      dec_wr_en <= nxt_wr_en;
    end
  end

endmodule

/* rtl/rename/rename_map.sv */
module rename_map (
  input  logic clk,
  input  logic rst,
  input  logic [rename_pkg::SLOTS-1:0][rename_pkg::AREG_W-1:0] rs1,
  input  logic [rename_pkg::SLOTS-1:0][rename_pkg::AREG_W-1:0] rs2,
  input  logic [rename_pkg::SLOTS-1:0][rename_pkg::AREG_W-1:0] rd,
  input  logic [rename_pkg::SLOTS-1:0] wr_en,
  input  logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] new_preg,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] psrc1,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] psrc2,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] pold
);
  import rename_pkg::*;

  // speculative arch to phys table
  logic [ARCH_REGS-1:0][PREG_W-1:0] map_q;

  // lookups, each slot sees the writes of all older slots in the group
  always_comb begin
    for (int s = 0; s < SLOTS; s++) begin
      psrc1[s] = map_q[rs1[s]];
      psrc2[s] = map_q[rs2[s]];
      pold[s] = map_q[rd[s]];
      // youngest older writer wins
      for (int o = 0; o < s; o++) begin
        if (wr_en[o] && rd[o] == rs1[s]) begin
          psrc1[s] = new_preg[o];
        end
        if (wr_en[o] && rd[o] == rs2[s]) begin
          psrc2[s] = new_preg[o];
        end
        if (wr_en[o] && rd[o] == rd[s]) begin
          pold[s] = new_preg[o];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      // identity mapping out of reset
      for (int a = 0; a < ARCH_REGS; a++) begin
        map_q[a] <= PREG_W'(a);
      end
    end else begin
      // later slot overrides on same rd
      for (int s = 0; s < SLOTS; s++) begin
        if (wr_en[s]) begin
          map_q[rd[s]] <= new_preg[s];
        end
      end
    end
  end

endmodule

/* rtl/rename/free_list.sv */
module free_list (
  input  logic clk,
  input  logic rst,
  input  logic [rename_pkg::SLOTS-1:0] pop_en,
  input  logic [rename_pkg::SLOTS-1:0] push_en,
  input  logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] push_reg,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] head_preg,
  output logic [rename_pkg::FREE_CNT_W-1:0] num_free
);
  import rename_pkg::*;

  // circular queue of free phys reg numbers
  logic [PHYS_REGS-1:0][PREG_W-1:0] fifo_q;

  // tail is the read side, head the write side
  // both wrap naturally at PHYS_REGS
  logic [PREG_W-1:0] tail_q;
  logic [PREG_W-1:0] head_q;
  logic [FREE_CNT_W-1:0] count_q;

  logic [FREE_CNT_W-1:0] num_pop;
  logic [FREE_CNT_W-1:0] num_push;
  logic [SLOTS-1:0][PREG_W-1:0] push_addr;

  always_comb begin
    num_pop = '0;
    num_push = '0;
    for (int s = 0; s < SLOTS; s++) begin
      // pushes packed in slot order behind head
      push_addr[s] = head_q + PREG_W'(num_push);
      num_push = num_push + FREE_CNT_W'(push_en[s]);
      num_pop = num_pop + FREE_CNT_W'(pop_en[s]);
    end
  end

  // oldest free regs first
  always_comb begin
    for (int s = 0; s < SLOTS; s++) begin
      head_preg[s] = fifo_q[tail_q + PREG_W'(s)];
    end
  end

  assign num_free = count_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      // regs above the arch set start out free, lowest first
      tail_q <= '0;
      head_q <= PREG_W'(PHYS_REGS - ARCH_REGS);
      count_q <= FREE_CNT_W'(PHYS_REGS - ARCH_REGS);
      for (int i = 0; i < PHYS_REGS; i++) begin
        fifo_q[i] <= PREG_W'(ARCH_REGS + i);
      end
    end else begin
      for (int s = 0; s < SLOTS; s++) begin
        if (push_en[s]) begin
          fifo_q[push_addr[s]] <= push_reg[s];
        end
      end
      tail_q <= tail_q + PREG_W'(num_pop);
      head_q <= head_q + PREG_W'(num_push);
      // callers keep this within 0..PHYS_REGS
      count_q <= count_q + num_push - num_pop;
    end
  end

endmodule

/* rtl/rename/rename_stage.sv */
module rename_stage (
  input  logic clk,
  input  logic rst,
  input  logic dec_valid,
  output logic dec_ready,
  input  logic [rename_pkg::SLOTS-1:0] dec_slot_en,
  input  logic [rename_pkg::SLOTS-1:0][rename_pkg::AREG_W-1:0] dec_rs1,
  input  logic [rename_pkg::SLOTS-1:0][rename_pkg::AREG_W-1:0] dec_rs2,
  input  logic [rename_pkg::SLOTS-1:0] dec_rs2_en,
  input  logic [rename_pkg::SLOTS-1:0][rename_pkg::AREG_W-1:0] dec_rd,
  input  logic [rename_pkg::SLOTS-1:0] dec_wr_en,
  output logic ren_valid,
  input  logic ren_ready,
  output logic [rename_pkg::SLOTS-1:0] ren_slot_en,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] ren_pdst,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] ren_psrc1,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] ren_psrc2,
  output logic [rename_pkg::SLOTS-1:0] ren_src2_en,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] ren_pold,
  output logic [rename_pkg::SLOTS-1:0] ren_wr_en,
  input  logic [rename_pkg::FREE_CNT_W-1:0] num_free,
  input  logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] head_preg,
  output logic [rename_pkg::SLOTS-1:0] pop_en,
  input  logic [rename_pkg::RQ_CNT_W-1:0] rq_space,
  output logic [rename_pkg::SLOTS-1:0] rq_push_en,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] rq_pold,
  output logic [rename_pkg::SLOTS-1:0] rq_wr_en
);
  import rename_pkg::*;

  logic [FREE_CNT_W-1:0] wr_cnt;
  logic [RQ_CNT_W-1:0] uop_cnt;
  logic [SLOTS-1:0][PREG_W-1:0] new_preg;
  logic [SLOTS-1:0] map_wr;
  logic [SLOTS-1:0][PREG_W-1:0] psrc1;
  logic [SLOTS-1:0][PREG_W-1:0] psrc2;
  logic [SLOTS-1:0][PREG_W-1:0] pold;
  logic out_free;
  logic accept;
  int unsigned alloc_idx;

  // count demand and hand out free regs to writers in slot order
  always_comb begin
    wr_cnt = '0;
    uop_cnt = '0;
    alloc_idx = 0;
    for (int s = 0; s < SLOTS; s++) begin
      new_preg[s] = head_preg[alloc_idx];
      alloc_idx = alloc_idx + 32'(dec_wr_en[s]);
      wr_cnt = wr_cnt + FREE_CNT_W'(dec_wr_en[s]);
      uop_cnt = uop_cnt + RQ_CNT_W'(dec_slot_en[s]);
    end
  end

  // output reg empty or draining
  assign out_free = !ren_valid || ren_ready;
  // shortage of regs or queue space stalls like back-pressure
  assign dec_ready = out_free && (num_free >= wr_cnt) && (rq_space >= uop_cnt);
  assign accept = dec_valid && dec_ready;

  // map, free list and retire queue all move on the accept edge
  assign map_wr = dec_wr_en & {SLOTS{accept}};
  assign pop_en = map_wr;
  assign rq_push_en = dec_slot_en & {SLOTS{accept}};
  assign rq_pold = pold;
  assign rq_wr_en = dec_wr_en;

  rename_map u_rename_map (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec_rs1),
    .rs2      (dec_rs2),
    .rd       (dec_rd),
    .wr_en    (map_wr),
    .new_preg (new_preg),
    .psrc1    (psrc1),
    .psrc2    (psrc2),
    .pold     (pold)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      ren_valid <= 1'b0;
    end else if (out_free) begin
      ren_valid <= accept;
    end
  end

  // renamed group, held while ren_ready is low
  always_ff @(posedge clk) begin
    if (accept) begin
      ren_slot_en <= dec_slot_en;
      ren_psrc1 <= psrc1;
      ren_psrc2 <= psrc2;
      ren_src2_en <= dec_rs2_en;
      ren_wr_en <= dec_wr_en;
      for (int s = 0; s < SLOTS; s++) begin
        // non-writing slots carry zero dst and pold
        ren_pdst[s] <= dec_wr_en[s] ? new_preg[s] : '0;
        ren_pold[s] <= dec_wr_en[s] ? pold[s] : '0;
      end
    end
  end

endmodule

/* rtl/retire_queue.sv */
module retire_queue (
  input  logic clk,
  input  logic rst,
  input  logic [rename_pkg::SLOTS-1:0] rq_push_en,
  input  logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] rq_pold,
  input  logic [rename_pkg::SLOTS-1:0] rq_wr_en,
  output logic [rename_pkg::RQ_CNT_W-1:0] rq_space,
  input  logic commit_valid,
  input  logic commit_two,
  output logic commit_ready,
  output logic [rename_pkg::SLOTS-1:0] freed_en,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] freed_preg
);
  import rename_pkg::*;

  // per entry: replaced phys reg and whether the uop wrote at all
  logic [RQ_DEPTH-1:0][PREG_W-1:0] pold_q;
  logic [RQ_DEPTH-1:0] wr_q;

  logic [RQ_PTR_W-1:0] rd_ptr;
  logic [RQ_PTR_W-1:0] wr_ptr;
  logic [RQ_CNT_W-1:0] count_q;

  logic [RQ_CNT_W-1:0] commit_cnt;
  logic [RQ_CNT_W-1:0] num_push;
  logic [RQ_CNT_W-1:0] num_pop;
  logic [SLOTS-1:0][RQ_PTR_W-1:0] push_addr;
  logic commit_fire;

  assign rq_space = RQ_CNT_W'(RQ_DEPTH) - count_q;

  // one or two oldest uops per handshake
  assign commit_cnt = commit_two ? RQ_CNT_W'(2) : RQ_CNT_W'(1);
  assign commit_ready = count_q >= commit_cnt;
  assign commit_fire = commit_valid && commit_ready;
  assign num_pop = commit_fire ? commit_cnt : '0;

  always_comb begin
    num_push = '0;
    for (int s = 0; s < SLOTS; s++) begin
      push_addr[s] = wr_ptr + RQ_PTR_W'(num_push);
      num_push = num_push + RQ_CNT_W'(rq_push_en[s]);
    end
  end

  // freed regs go straight to the free list on the commit edge
  always_comb begin
    for (int s = 0; s < SLOTS; s++) begin
      freed_preg[s] = pold_q[rd_ptr + RQ_PTR_W'(s)];
      freed_en[s] = commit_fire && (RQ_CNT_W'(s) < commit_cnt) &&
                    wr_q[rd_ptr + RQ_PTR_W'(s)];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count_q <= '0;
    end else begin
      rd_ptr <= rd_ptr + RQ_PTR_W'(num_pop);
      wr_ptr <= wr_ptr + RQ_PTR_W'(num_push);
      count_q <= count_q + num_push - num_pop;
    end
  end

  // entry payload, meaningful only below count_q
  always_ff @(posedge clk) begin
    for (int s = 0; s < SLOTS; s++) begin
      if (rq_push_en[s]) begin
        pold_q[push_addr[s]] <= rq_pold[s];
        wr_q[push_addr[s]] <= rq_wr_en[s];
      end
    end
  end

endmodule

/* rtl/rename_top.sv */
module rename_top (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  output logic in_ready,
  input  logic [rename_pkg::SLOTS-1:0] in_slot_en,
  input  rename_pkg::insn_word_t [rename_pkg::SLOTS-1:0] in_insn,
  output logic ren_valid,
  input  logic ren_ready,
  output logic [rename_pkg::SLOTS-1:0] ren_slot_en,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] ren_pdst,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] ren_psrc1,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] ren_psrc2,
  output logic [rename_pkg::SLOTS-1:0] ren_src2_en,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] ren_pold,
  output logic [rename_pkg::SLOTS-1:0] ren_wr_en,
  input  logic commit_valid,
  input  logic commit_two,
  output logic commit_ready,
  output logic [rename_pkg::SLOTS-1:0] freed_en,
  output logic [rename_pkg::SLOTS-1:0][rename_pkg::PREG_W-1:0] freed_preg
);
  import rename_pkg::*;

  // decode to rename
  logic dec_valid;
  logic dec_ready;
  logic [SLOTS-1:0] dec_slot_en;
  logic [SLOTS-1:0][AREG_W-1:0] dec_rs1;
  logic [SLOTS-1:0][AREG_W-1:0] dec_rs2;
  logic [SLOTS-1:0] dec_rs2_en;
  logic [SLOTS-1:0][AREG_W-1:0] dec_rd;
  logic [SLOTS-1:0] dec_wr_en;

  // free list and retire queue hookup
  logic [FREE_CNT_W-1:0] num_free;
  logic [SLOTS-1:0][PREG_W-1:0] head_preg;
  logic [SLOTS-1:0] pop_en;
  logic [RQ_CNT_W-1:0] rq_space;
  logic [SLOTS-1:0] rq_push_en;
  logic [SLOTS-1:0][PREG_W-1:0] rq_pold;
  logic [SLOTS-1:0] rq_wr_en;

  insn_decode u_insn_decode (
    .clk(clk), .rst(rst),
    .in_valid(in_valid), .in_ready(in_ready),
    .in_slot_en(in_slot_en), .in_insn(in_insn),
    .dec_valid(dec_valid), .dec_ready(dec_ready),
    .dec_slot_en(dec_slot_en), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
    .dec_rs2_en(dec_rs2_en), .dec_rd(dec_rd), .dec_wr_en(dec_wr_en)
  );

  rename_stage u_rename_stage (
    .clk(clk), .rst(rst),
    .dec_valid(dec_valid), .dec_ready(dec_ready),
    .dec_slot_en(dec_slot_en), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
    .dec_rs2_en(dec_rs2_en), .dec_rd(dec_rd), .dec_wr_en(dec_wr_en),
    .ren_valid(ren_valid), .ren_ready(ren_ready), .ren_slot_en(ren_slot_en),
    .ren_pdst(ren_pdst), .ren_psrc1(ren_psrc1), .ren_psrc2(ren_psrc2),
    .ren_src2_en(ren_src2_en), .ren_pold(ren_pold), .ren_wr_en(ren_wr_en),
    .num_free(num_free), .head_preg(head_preg), .pop_en(pop_en),
    .rq_space(rq_space), .rq_push_en(rq_push_en),
    .rq_pold(rq_pold), .rq_wr_en(rq_wr_en)
  );

  retire_queue u_retire_queue (
    .clk(clk), .rst(rst),
    .rq_push_en(rq_push_en), .rq_pold(rq_pold), .rq_wr_en(rq_wr_en),
    .rq_space(rq_space),
    .commit_valid(commit_valid), .commit_two(commit_two),
    .commit_ready(commit_ready),
    .freed_en(freed_en), .freed_preg(freed_preg)
  );

  // committed old regs return to the free list
  free_list u_free_list (
    .clk(clk), .rst(rst),
    .pop_en(pop_en), .push_en(freed_en), .push_reg(freed_preg),
    .head_preg(head_preg), .num_free(num_free)
  );

endmodule

/* bench/tb_clock.sv */
module tb_clock (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  // 4 ns period
  localparam int HALF_PERIOD_NS = 2;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

endmodule

/* bench/rename_model.svh */
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// slot kinds the stimulus picks from
localparam logic [1:0] KIND_OP = 2'd0;
localparam logic [1:0] KIND_IMM = 2'd1;
localparam logic [1:0] KIND_OTHER = 2'd2;

// one group in the arch fields it was built from
typedef struct packed {
  logic [SLOTS-1:0] en;
  logic [SLOTS-1:0][1:0] kind;
  logic [SLOTS-1:0][AREG_W-1:0] rs1;
  logic [SLOTS-1:0][AREG_W-1:0] rs2;
  logic [SLOTS-1:0][AREG_W-1:0] rd;
} group_t;

// map, free FIFO and retire order
logic [PREG_W-1:0] model_map [ARCH_REGS];
logic [PREG_W-1:0] model_free [$];
logic [PREG_W-1:0] model_rq_pold [$];
logic model_rq_wr [$];

// expected renamed group
logic [SLOTS-1:0] exp_wr;
logic [SLOTS-1:0] exp_src2_en;
logic [SLOTS-1:0][PREG_W-1:0] exp_pdst;
logic [SLOTS-1:0][PREG_W-1:0] exp_psrc1;
logic [SLOTS-1:0][PREG_W-1:0] exp_psrc2;
logic [SLOTS-1:0][PREG_W-1:0] exp_pold;

task automatic model_reset();
  model_free.delete();
  model_rq_pold.delete();
  model_rq_wr.delete();
  // identity map, regs above the arch set free in order
  for (int a = 0; a < ARCH_REGS; a++) begin
    model_map[a] = PREG_W'(a);
  end
  for (int p = ARCH_REGS; p < PHYS_REGS; p++) begin
    model_free.push_back(PREG_W'(p));
  end
endtask

// slots in program order, so slot 1 sees what slot 0 wrote
task automatic model_rename(input group_t g);
  for (int s = 0; s < SLOTS; s++) begin
    exp_wr[s] = g.en[s] && (g.kind[s] != KIND_OTHER) && (g.rd[s] != '0);
    exp_src2_en[s] = g.en[s] && (g.kind[s] == KIND_OP);
    // sources read before this slot's own write
    exp_psrc1[s] = model_map[g.rs1[s]];
    exp_psrc2[s] = model_map[g.rs2[s]];
    exp_pdst[s] = '0;
    exp_pold[s] = '0;
    if (exp_wr[s]) begin
      exp_pdst[s] = model_free.pop_front();
      exp_pold[s] = model_map[g.rd[s]];
      model_map[g.rd[s]] = exp_pdst[s];
    end
    if (g.en[s]) begin
      model_rq_pold.push_back(exp_pold[s]);
      model_rq_wr.push_back(exp_wr[s]);
    end
  end
endtask

// oldest n uops retire, replaced regs rejoin the free FIFO
task automatic model_commit(input int n, output logic [SLOTS-1:0] en,
                            output logic [SLOTS-1:0][PREG_W-1:0] preg);
  en = '0;
  preg = '0;
  for (int s = 0; s < n; s++) begin
    en[s] = model_rq_wr.pop_front();
    preg[s] = model_rq_pold.pop_front();
    if (en[s]) begin
      model_free.push_back(preg[s]);
    end
  end
endtask

`endif

/* bench/rename_tb.sv */
module rename_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rename_pkg::*;

  localparam int NUM_GROUPS = 400;
  localparam int CLK_PERIOD_NS = 4;
  localparam int RESET_CYCLES = 4;
  // long enough for the retire queue to fill and stall rename
  localparam int NO_COMMIT_CYCLES = 120;
  localparam int WATCHDOG_NS = NUM_GROUPS * 40 * CLK_PERIOD_NS;
  localparam logic [31:0] LCG_SEED = 32'hced36fb0;
  // branch, reads sources and writes nothing
  localparam logic [6:0] OPC_OTHER = 7'b1100011;

  logic clk;
  logic rst;
  logic in_valid;
  logic in_ready;
  logic [SLOTS-1:0] in_slot_en;
  insn_word_t [SLOTS-1:0] in_insn;
  logic ren_valid;
  logic ren_ready;
  logic [SLOTS-1:0] ren_slot_en;
  logic [SLOTS-1:0][PREG_W-1:0] ren_pdst;
  logic [SLOTS-1:0][PREG_W-1:0] ren_psrc1;
  logic [SLOTS-1:0][PREG_W-1:0] ren_psrc2;
  logic [SLOTS-1:0] ren_src2_en;
  logic [SLOTS-1:0][PREG_W-1:0] ren_pold;
  logic [SLOTS-1:0] ren_wr_en;
  logic commit_valid;
  logic commit_two;
  logic commit_ready;
  logic [SLOTS-1:0] freed_en;
  logic [SLOTS-1:0][PREG_W-1:0] freed_preg;

  `include "rename_model.svh"

  logic [31:0] lcg_state;
  group_t cur_group;
  group_t pend_q [$];
  int groups_in;
  int groups_out;
  int cycle;
  logic in_fire;
  logic held;
  // ren outputs seen while stalled
  logic [SLOTS-1:0] snap_slot_en;
  logic [SLOTS-1:0][PREG_W-1:0] snap_pdst;
  logic [SLOTS-1:0][PREG_W-1:0] snap_psrc1;
  logic [SLOTS-1:0][PREG_W-1:0] snap_psrc2;
  logic [SLOTS-1:0] snap_src2_en;
  logic [SLOTS-1:0][PREG_W-1:0] snap_pold;
  logic [SLOTS-1:0] snap_wr_en;

  tb_clock u_tb_clock (.clk(clk));

  rename_top u_rename_top (
    .clk(clk), .rst(rst),
    .in_valid(in_valid), .in_ready(in_ready),
    .in_slot_en(in_slot_en), .in_insn(in_insn),
    .ren_valid(ren_valid), .ren_ready(ren_ready), .ren_slot_en(ren_slot_en),
    .ren_pdst(ren_pdst), .ren_psrc1(ren_psrc1), .ren_psrc2(ren_psrc2),
    .ren_src2_en(ren_src2_en), .ren_pold(ren_pold), .ren_wr_en(ren_wr_en),
    .commit_valid(commit_valid), .commit_two(commit_two),
    .commit_ready(commit_ready),
    .freed_en(freed_en), .freed_preg(freed_preg)
  );

  task automatic fail_with(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      fail_with($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  // upper half of the lcg state is the better random part
  function automatic logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  task automatic load_next_group();
    logic [15:0] r;
    logic [15:0] f;
    r = rand16();
    // never an empty group
    cur_group.en = (r[1:0] == 2'b00) ? 2'b11 : r[1:0];
    in_insn = '0;
    for (int s = 0; s < SLOTS; s++) begin
      r = rand16();
      f = rand16();
      cur_group.kind[s] = (r[1:0] == 2'd3) ? KIND_OTHER : (r[0] ? KIND_IMM : KIND_OP);
      // regs 0..7 only, so slots collide often
      cur_group.rs1[s] = {2'b00, r[4:2]};
      cur_group.rs2[s] = {2'b00, r[7:5]};
      cur_group.rd[s] = {2'b00, r[10:8]};
      if (cur_group.kind[s] == KIND_IMM) begin
        in_insn[s].i.imm12 = f[11:0];
        in_insn[s].i.rs1 = cur_group.rs1[s];
        in_insn[s].i.funct3 = f[14:12];
        in_insn[s].i.rd = cur_group.rd[s];
        in_insn[s].i.opcode = OPC_IMM;
      end else begin
        in_insn[s].r.funct7 = f[6:0];
        in_insn[s].r.rs2 = cur_group.rs2[s];
        in_insn[s].r.rs1 = cur_group.rs1[s];
        in_insn[s].r.funct3 = f[9:7];
        in_insn[s].r.rd = cur_group.rd[s];
        in_insn[s].r.opcode = (cur_group.kind[s] == KIND_OP) ? OPC_OP : OPC_OTHER;
      end
    end
    in_slot_en = cur_group.en;
    in_valid = 1'b1;
  endtask

  task automatic drive_inputs();
    logic [15:0] r;
    r = rand16();
    // a group stays on the bus until taken
    if (!in_valid || in_fire) begin
      in_valid = 1'b0;
      if (groups_in < NUM_GROUPS && r[1:0] != 2'd0) begin
        load_next_group();
      end
    end
    ren_ready = r[3:2] != 2'd0;
    commit_two = r[4];
    // commit only uops the model has already seen leave rename
    commit_valid = (cycle >= NO_COMMIT_CYCLES) && r[5] &&
                   (model_rq_wr.size() >= (r[4] ? 2 : 1));
  endtask

  task automatic check_renamed(input group_t g);
    check_value("ren_slot_en", 64'(ren_slot_en), 64'(g.en));
    check_value("ren_wr_en", 64'(ren_wr_en), 64'(exp_wr));
    for (int s = 0; s < SLOTS; s++) begin
      if (g.en[s]) begin
        check_value($sformatf("ren_src2_en[%0d]", s), 64'(ren_src2_en[s]),
                    64'(exp_src2_en[s]));
        check_value($sformatf("ren_psrc1[%0d]", s), 64'(ren_psrc1[s]), 64'(exp_psrc1[s]));
        if (exp_src2_en[s]) begin
          check_value($sformatf("ren_psrc2[%0d]", s), 64'(ren_psrc2[s]), 64'(exp_psrc2[s]));
        end
        if (exp_wr[s]) begin
          check_value($sformatf("ren_pdst[%0d]", s), 64'(ren_pdst[s]), 64'(exp_pdst[s]));
          check_value($sformatf("ren_pold[%0d]", s), 64'(ren_pold[s]), 64'(exp_pold[s]));
        end
      end
    end
  endtask

  // values here are what the next rising edge will take
  task automatic sample_outputs();
    logic [SLOTS-1:0] exp_free_en;
    logic [SLOTS-1:0][PREG_W-1:0] exp_free_preg;
    group_t g;
    if (held) begin
      check_value("ren_valid", 64'(ren_valid), 64'(1));
      check_value("ren_slot_en", 64'(ren_slot_en), 64'(snap_slot_en));
      check_value("ren_pdst", 64'(ren_pdst), 64'(snap_pdst));
      check_value("ren_psrc1", 64'(ren_psrc1), 64'(snap_psrc1));
      check_value("ren_psrc2", 64'(ren_psrc2), 64'(snap_psrc2));
      check_value("ren_src2_en", 64'(ren_src2_en), 64'(snap_src2_en));
      check_value("ren_pold", 64'(ren_pold), 64'(snap_pold));
      check_value("ren_wr_en", 64'(ren_wr_en), 64'(snap_wr_en));
    end
    if (commit_valid) begin
      check_value("commit_ready", 64'(commit_ready), 64'(1));
      model_commit(commit_two ? 2 : 1, exp_free_en, exp_free_preg);
      check_value("freed_en", 64'(freed_en), 64'(exp_free_en));
      for (int s = 0; s < SLOTS; s++) begin
        if (exp_free_en[s]) begin
          check_value($sformatf("freed_preg[%0d]", s), 64'(freed_preg[s]),
                      64'(exp_free_preg[s]));
        end
      end
    end else begin
      check_value("freed_en", 64'(freed_en), 64'(0));
    end
    if (ren_valid && ren_ready) begin
      if (pend_q.size() == 0) begin
        fail_with("Error: a renamed group came out that was never sent in");
      end
      g = pend_q.pop_front();
      model_rename(g);
      check_renamed(g);
      if (model_rq_wr.size() > RQ_DEPTH) begin
        fail_with("Error: more uops renamed than the retire queue can hold");
      end
      groups_out++;
    end
    held = ren_valid && !ren_ready;
    snap_slot_en = ren_slot_en;
    snap_pdst = ren_pdst;
    snap_psrc1 = ren_psrc1;
    snap_psrc2 = ren_psrc2;
    snap_src2_en = ren_src2_en;
    snap_pold = ren_pold;
    snap_wr_en = ren_wr_en;
    in_fire = in_valid && in_ready;
    if (in_fire) begin
      pend_q.push_back(cur_group);
      groups_in++;
    end
    cycle++;
  endtask

  initial begin
    rst = 1'b1;
    in_valid = 1'b0;
    in_slot_en = '0;
    in_insn = '0;
    ren_ready = 1'b0;
    commit_valid = 1'b0;
    commit_two = 1'b0;
    lcg_state = LCG_SEED;
    groups_in = 0;
    groups_out = 0;
    cycle = 0;
    in_fire = 1'b0;
    held = 1'b0;
    model_reset();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    // idle pipeline and empty retire queue
    check_value("ren_valid", 64'(ren_valid), 64'(0));
    check_value("in_ready", 64'(in_ready), 64'(1));
    check_value("freed_en", 64'(freed_en), 64'(0));
    check_value("commit_ready", 64'(commit_ready), 64'(0));
    while (groups_out < NUM_GROUPS) begin
      @(posedge clk);
      #1;
      drive_inputs();
      @(negedge clk);
      sample_outputs();
    end
    $display("All checks passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    fail_with("Error: timeout, not all groups came out of rename in time");
  end

endmodule

/* sources.f */
+incdir+bench
common/rename_pkg.sv
rtl/decode/insn_decode.sv
rtl/rename/rename_map.sv
rtl/rename/free_list.sv
rtl/rename/rename_stage.sv
rtl/retire_queue.sv
rtl/rename_top.sv
bench/tb_clock.sv
bench/rename_tb.sv

/* run.sh */
#!/bin/sh
# build and run the rename testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps --top-module rename_tb \
    -f sources.f -o rename_sim; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/rename_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
  exit 0
else
  exit 1
fi
